/* lc4_vectors.txt */
// Columns: pc_insn_ldata_we_addr_towrite_tag, all hex, one instruction per cycle
// Tags: 01 reset, 02 alu ops, 03 load, 04 branch, 05 control, FF end of vectors
8200_0000_0000_0_0000_0000_01
8201_0000_0000_0_0000_0000_01
8202_9205_0000_0_0000_0000_02
8203_95FD_0000_0_0000_0000_02
8204_D512_0000_0_0000_0000_02
8205_747E_0000_1_0003_12FD_02
8206_1642_0000_0_0000_0000_02
8207_7601_0000_1_0001_1302_02
8208_1879_0000_0_0000_0000_02
8209_7802_0000_1_0002_FFFE_02
820A_1A91_0000_0_0000_0000_02
820B_7A43_0000_1_0008_12F8_02
820C_1C89_0000_0_0000_0000_02
820D_7C05_0000_1_0005_5EF1_02
820E_5686_0000_0_0000_0000_02
820F_7606_0000_1_0006_12F1_02
8210_5852_0000_0_0000_0000_02
8211_7807_0000_1_0007_12FD_02
8212_5A9E_0000_0_0000_0000_02
8213_7A08_0000_1_0008_4C0C_02
8214_5C48_0000_0_0000_0000_02
8215_7C09_0000_1_0009_FFFA_02
8216_5EAE_0000_0_0000_0000_02
8217_7E0A_0000_1_000A_000C_02
8218_6644_A5C3_0_0009_0000_03
8219_760B_0000_1_000B_A5C3_03
821A_0802_0000_0_0000_0000_04
821D_9800_0000_0_0000_0000_04
821E_0A05_0000_0_0000_0000_04
821F_05F0_0000_0_0000_0000_04
8210_1923_0000_0_0000_0000_04
8211_0603_0000_0_0000_0000_04
8215_0808_0000_0_0000_0000_04
8216_0E20_0000_0_0000_0000_04
8237_C810_0000_0_0000_0000_05
8248_CFFC_0000_0_0000_0000_05
8245_4923_0000_0_0000_0000_05
9230_7E0C_0000_1_000C_8246_05
9231_9A40_0000_0_0000_0000_05
9232_DB86_0000_0_0000_0000_05
9233_C140_0000_0_0000_0000_05
8640_9C1F_0000_0_0000_0000_05
8641_DDA1_0000_0_0000_0000_05
8642_4180_0000_0_0000_0000_05
A11F_7E7B_0000_1_0000_8643_05
A120_F025_0000_0_0000_0000_05
8025_7E0D_0000_1_000D_A121_05
8026_8000_0000_0_0000_0000_05
A121_0000_0000_0_0000_0000_05
0000_0000_0000_0_0000_0000_FF

/* filelist.f */
lc4_isa_pkg.sv
lc4_ctrl_pkg.sv
lc4_decoder.sv
lc4_regfile.sv
lc4_alu.sv
lc4_branch_unit.sv
lc4_processor.sv
tb_lc4_processor.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the LC4 core testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_lc4_processor \
   -o sim_lc4 > build.log 2>&1 \
   && ./obj_dir/sim_lc4 > sim.log 2>&1 \
   || echo "Build or simulation error, see build.log and sim.log"

grep -qx "Result: PASSED" sim.log && echo "Simulation passed" \
   || { echo "Simulation failed, see sim.log"; exit 1; }

/* tb_lc4_processor.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_lc4_processor;

   import lc4_isa_pkg::*;

   // One row of lc4_vectors.txt, first field in the top bits
   typedef struct packed {
      word_t      pc;
      word_t      insn;
      word_t      ldata;
      logic [3:0] we;
      word_t      addr;
      word_t      data;
      logic [7:0] tag;
   } vector_t;

   localparam int         MAX_VECTORS  = 64;
   localparam int         RESET_CYCLES = 4;
   // Margin on top of reset and vector cycles
   localparam int         SLACK_CYCLES = 20;
   localparam logic [7:0] END_TAG      = 8'hFF;
   // Boot address of the LC4 core
   localparam word_t      BOOT_PC      = 16'h8200;

   logic  gwe;
   logic  i_rst_n;
   word_t i_cur_insn;
   word_t i_cur_dmem_data;
   word_t o_cur_pc;
   word_t o_dmem_addr;
   logic  o_dmem_we;
   word_t o_dmem_towrite;

   logic [$bits(vector_t)-1:0] vec_mem [MAX_VECTORS];

   int num_vectors;
   int cycle_count;
   int cycle_limit = RESET_CYCLES + MAX_VECTORS + SLACK_CYCLES;
   int error_count;
   int test_errors;
   int check_count;
   int test_count;

   lc4_processor dut0 (
      .gwe             (gwe),
      .i_rst_n         (i_rst_n),
      .i_cur_insn      (i_cur_insn),
      .i_cur_dmem_data (i_cur_dmem_data),
      .o_cur_pc        (o_cur_pc),
      .o_dmem_addr     (o_dmem_addr),
      .o_dmem_we       (o_dmem_we),
      .o_dmem_towrite  (o_dmem_towrite)
   );

   // 100 ns period
   always #50 gwe = ~gwe;

   // Stop a run that never reaches the end of the vectors
   always @(posedge gwe) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         $display("Error: run did not finish within %0d cycles", cycle_limit);
         $display("Result: FAILED");
         $finish;
      end
   end

   function automatic string test_name(input logic [7:0] tag);
      case (tag)
         8'h01:   return "reset";
         8'h02:   return "alu_ops";
         8'h03:   return "load";
         8'h04:   return "branch";
         8'h05:   return "control";
         default: return "unknown";
      endcase
   endfunction

   // Rows up to the end marker
   function automatic int count_vectors();
      int      n;
      vector_t row;
      n   = 0;
      row = vector_t'(vec_mem[0]);
      while (n < MAX_VECTORS && row.tag != END_TAG) begin
         n++;
         if (n < MAX_VECTORS) begin
            row = vector_t'(vec_mem[n]);
         end
      end
      return n;
   endfunction

   task automatic check_value(input string name, input word_t expected, input word_t actual);
      check_count++;
      if (expected !== actual) begin
         error_count++;
         test_errors++;
         $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic report_test(input logic [7:0] tag);
      test_count++;
      $display("Test %0d (%s) finished with %0d mismatches", tag, test_name(tag), test_errors);
      test_errors = 0;
   endtask

   initial begin
      vector_t    v;
      logic [7:0] cur_tag;
      gwe             = 1'b0;
      i_rst_n         = 1'b0;
      // NOP during reset, a BR with an empty mask
      i_cur_insn      = 16'h0000;
      i_cur_dmem_data = 16'h0000;
      cycle_count     = 0;
      error_count     = 0;
      test_errors     = 0;
      check_count     = 0;
      test_count      = 0;

      // Unread rows look like the end marker
      for (int i = 0; i < MAX_VECTORS; i++) begin
         vec_mem[i] = '1;
      end
      $readmemh("lc4_vectors.txt", vec_mem);
      num_vectors = count_vectors();
      cycle_limit = RESET_CYCLES + num_vectors + SLACK_CYCLES;
      if (num_vectors == 0) begin
         $display("Error: no vectors could be read from lc4_vectors.txt");
         error_count++;
      end
      v       = vector_t'(vec_mem[0]);
      cur_tag = v.tag;

      // PC parked at the boot address and no store while in reset
      repeat (RESET_CYCLES) begin
         @(posedge gwe);
         #1;
         check_value("reset pc during reset", BOOT_PC, o_cur_pc);
         check_value("reset dmem_we during reset", 16'h0000, {15'b0, o_dmem_we});
      end
      i_rst_n = 1'b1;

      for (int i = 0; i < num_vectors; i++) begin
         v = vector_t'(vec_mem[i]);
         if (v.tag != cur_tag) begin
            report_test(cur_tag);
            cur_tag = v.tag;
         end
         i_cur_insn      = v.insn;
         i_cur_dmem_data = v.ldata;
         // Outputs are settled by mid-cycle
         @(negedge gwe);
         check_value($sformatf("%s pc, vector %0d", test_name(v.tag), i), v.pc, o_cur_pc);
         check_value($sformatf("%s dmem_we, vector %0d", test_name(v.tag), i),
                     {12'b0, v.we}, {15'b0, o_dmem_we});
         check_value($sformatf("%s dmem_addr, vector %0d", test_name(v.tag), i),
                     v.addr, o_dmem_addr);
         check_value($sformatf("%s dmem_towrite, vector %0d", test_name(v.tag), i),
                     v.data, o_dmem_towrite);
         @(posedge gwe);
         #1;
      end
      if (num_vectors > 0) begin
         report_test(cur_tag);
      end

      $display("Tests: %0d, checks: %0d, mismatches: %0d", test_count, check_count,
               error_count);
      if (error_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* lc4_processor.sv */
`timescale 1ns/100ps
`default_nettype none

module lc4_processor (
   input  logic               gwe,
   input  logic               i_rst_n,
   input  lc4_isa_pkg::word_t i_cur_insn,
   input  lc4_isa_pkg::word_t i_cur_dmem_data,
   output lc4_isa_pkg::word_t o_cur_pc,
   output lc4_isa_pkg::word_t o_dmem_addr,
   output logic               o_dmem_we,
   output lc4_isa_pkg::word_t o_dmem_towrite
);

   import lc4_isa_pkg::*;
   import lc4_ctrl_pkg::*;

   ctrl_t     ctrl;
   word_t     rs_data;
   word_t     rt_data;
   word_t     alu_result;
   word_t     pc_plus_one;
   // Data written to the register file and tested for NZP
   word_t     wdata;
   dmem_req_t dmem_req;

   lc4_decoder u_decoder (
      .i_insn (i_cur_insn),
      .o_ctrl (ctrl)
   );

   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_rst_n   (i_rst_n),
      .i_rs      (ctrl.rs),
      .i_rt      (ctrl.rt),
      .i_rd      (ctrl.rd),
      .i_we      (ctrl.rf_we),
      .i_wdata   (wdata),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data)
   );

   lc4_alu u_alu (
      .i_ctrl     (ctrl),
      .i_rs_data  (rs_data),
      .i_rt_data  (rt_data),
      .o_result   (alu_result),
      .o_dmem_req (dmem_req)
   );

   lc4_branch_unit u_branch (
      .gwe           (gwe),
      .i_rst_n       (i_rst_n),
      .i_ctrl        (ctrl),
      .i_insn        (i_cur_insn),
      .i_rs_data     (rs_data),
      .i_wdata       (wdata),
      .o_pc          (o_cur_pc),
      .o_pc_plus_one (pc_plus_one)
   );

   // Writeback select
   always_comb begin
      case (ctrl.wb_src)
         WB_MEM:         wdata = i_cur_dmem_data;
         // Link value for JSR, JSRR and TRAP
         WB_PC_PLUS_ONE: wdata = pc_plus_one;
         default:        wdata = alu_result;
      endcase
   end

   // Memory request onto the data port
   assign o_dmem_we      = dmem_req.we;
   assign o_dmem_addr    = dmem_req.addr;
   assign o_dmem_towrite = dmem_req.data;

endmodule

`default_nettype wire

/* lc4_branch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module lc4_branch_unit (
   input  logic                gwe,
   input  logic                i_rst_n,
   input  lc4_ctrl_pkg::ctrl_t i_ctrl,
   input  lc4_isa_pkg::word_t  i_insn,
   input  lc4_isa_pkg::word_t  i_rs_data,
   input  lc4_isa_pkg::word_t  i_wdata,
   output lc4_isa_pkg::word_t  o_pc,
   output lc4_isa_pkg::word_t  o_pc_plus_one
);

   import lc4_isa_pkg::*;
   import lc4_ctrl_pkg::*;

   word_t      pc;
   word_t      pc_plus_one;
   word_t      next_pc;
   logic [2:0] nzp;
   logic [2:0] next_nzp;
   logic       br_taken;

   assign pc_plus_one = pc + 16'd1;

   // Condition of the value being written back
   always_comb begin
      if (i_wdata == '0) begin
         next_nzp = NZP_Z;
      end else if (i_wdata[15]) begin
         next_nzp = NZP_N;
      end else begin
         next_nzp = NZP_P;
      end
   end

   // Any NZP bit that matches the mask in insn[11:9]
   assign br_taken = |(nzp & i_insn[RD_HI:RD_LO]);

   always_comb begin
      case (i_ctrl.pc_src)
         PC_BRANCH:  next_pc = br_taken ? pc_plus_one + i_ctrl.imm : pc_plus_one;
         // Immediate already scaled by the decoder
         PC_JSR_IMM: next_pc = (pc & JSR_MASK) | i_ctrl.imm;
         PC_JMP_IMM: next_pc = pc_plus_one + i_ctrl.imm;
         PC_RS:      next_pc = i_rs_data;
         PC_TRAP:    next_pc = TRAP_BASE | i_ctrl.imm;
         default:    next_pc = pc_plus_one;
      endcase
   end

   // PC advances every cycle, NZP only when the instruction sets it
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc  <= RESET_PC;
         nzp <= '0;
      end else begin
         pc <= next_pc;
         if (i_ctrl.nzp_we) begin
            nzp <= next_nzp;
         end
      end
   end

   assign o_pc          = pc;
   assign o_pc_plus_one = pc_plus_one;

   // First fetch after reset comes from the boot address
   a_boot_pc : assert property (
      @(posedge gwe) $rose(i_rst_n) |-> (pc == RESET_PC)
   ) else $error("PC after reset is %h", pc);

endmodule

`default_nettype wire

/* lc4_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module lc4_alu (
   input  lc4_ctrl_pkg::ctrl_t     i_ctrl,
   input  lc4_isa_pkg::word_t      i_rs_data,
   input  lc4_isa_pkg::word_t      i_rt_data,
   output lc4_isa_pkg::word_t      o_result,
   output lc4_ctrl_pkg::dmem_req_t o_dmem_req
);

   import lc4_isa_pkg::*;
   import lc4_ctrl_pkg::*;

   // Second operand, register or immediate
   word_t op_b;
   word_t result;
   logic  mem_access;

   assign op_b       = i_ctrl.imm_sel ? i_ctrl.imm : i_rt_data;
   assign mem_access = i_ctrl.is_load | i_ctrl.is_store;

   always_comb begin
      case (i_ctrl.alu_op)
         ALU_ADD:      result = i_rs_data + op_b;
         // Low 16 bits of the product
         ALU_MUL:      result = i_rs_data * op_b;
         ALU_SUB:      result = i_rs_data - op_b;
         ALU_AND:      result = i_rs_data & op_b;
         ALU_NOT:      result = ~i_rs_data;
         ALU_OR:       result = i_rs_data | op_b;
         ALU_XOR:      result = i_rs_data ^ op_b;
         ALU_PASS_IMM: result = i_ctrl.imm;
         // New high byte, old low byte
         ALU_HI_MERGE: result = {i_ctrl.imm[7:0], i_rs_data[7:0]};
         default:      result = i_rs_data + op_b;
      endcase
   end

   assign o_result = result;

   // LDR and STR use the ADD path for rs + imm6
   always_comb begin
      o_dmem_req.we   = i_ctrl.is_store;
      o_dmem_req.addr = mem_access ? result : '0;
      o_dmem_req.data = i_ctrl.is_store ? i_rt_data : '0;
   end

endmodule

`default_nettype wire

/* lc4_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module lc4_regfile (
   input  logic                  gwe,
   input  logic                  i_rst_n,
   input  lc4_isa_pkg::reg_idx_t i_rs,
   input  lc4_isa_pkg::reg_idx_t i_rt,
   input  lc4_isa_pkg::reg_idx_t i_rd,
   input  logic                  i_we,
   input  lc4_isa_pkg::word_t    i_wdata,
   output lc4_isa_pkg::word_t    o_rs_data,
   output lc4_isa_pkg::word_t    o_rt_data
);

   import lc4_isa_pkg::*;

   // R0 to R7
   word_t regs [8];

   // Write lands at the rising edge
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // Reads see the old value during a write cycle
   assign o_rs_data = regs[i_rs];
   assign o_rt_data = regs[i_rt];

   // A write must carry a resolved value, or the register turns to X
   a_wdata_known : assert property (
      @(posedge gwe) disable iff (!i_rst_n)
      i_we |-> !$isunknown(i_wdata)
   ) else $error("Register write of unknown data to R%0d", i_rd);

endmodule

`default_nettype wire

/* lc4_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module lc4_decoder (
   input  lc4_isa_pkg::word_t  i_insn,
   output lc4_ctrl_pkg::ctrl_t o_ctrl
);

   import lc4_isa_pkg::*;
   import lc4_ctrl_pkg::*;

   opcode_e    opc;
   logic [2:0] sub;
   // Immediates in every width the ISA uses
   word_t      imm5;
   word_t      imm6;
   word_t      imm9;
   word_t      imm11;
   word_t      uimm8;

   assign opc   = opcode_e'(i_insn[OPC_HI:OPC_LO]);
   assign sub   = i_insn[SUB_HI:SUB_LO];
   assign imm5  = {{11{i_insn[4]}}, i_insn[4:0]};
   assign imm6  = {{10{i_insn[5]}}, i_insn[5:0]};
   assign imm9  = {{7{i_insn[8]}}, i_insn[8:0]};
   assign imm11 = {{5{i_insn[10]}}, i_insn[10:0]};
   assign uimm8 = {8'h00, i_insn[7:0]};

   always_comb begin
      // Plain register form unless the opcode says otherwise
      o_ctrl          = '0;
      o_ctrl.rs       = i_insn[RS_HI:RS_LO];
      o_ctrl.rt       = i_insn[RT_HI:RT_LO];
      o_ctrl.rd       = i_insn[RD_HI:RD_LO];
      o_ctrl.alu_op   = ALU_ADD;
      o_ctrl.wb_src   = WB_ALU;
      o_ctrl.pc_src   = PC_SEQ;
      case (opc)
         OP_BR: begin
            o_ctrl.pc_src = PC_BRANCH;
            o_ctrl.imm    = imm9;
         end
         OP_ARITH: begin
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
            if (i_insn[IMM_BIT]) begin
               o_ctrl.imm_sel = 1'b1;
               o_ctrl.imm     = imm5;
            end else begin
               case (sub)
                  3'b001:  o_ctrl.alu_op = ALU_MUL;
                  3'b010:  o_ctrl.alu_op = ALU_SUB;
                  // DIV is not implemented and falls back to ADD
                  default: o_ctrl.alu_op = ALU_ADD;
               endcase
            end
         end
         OP_LOGIC: begin
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
            o_ctrl.alu_op = ALU_AND;
            if (i_insn[IMM_BIT]) begin
               o_ctrl.imm_sel = 1'b1;
               o_ctrl.imm     = imm5;
            end else begin
               case (sub)
                  3'b001:  o_ctrl.alu_op = ALU_NOT;
                  3'b010:  o_ctrl.alu_op = ALU_OR;
                  3'b011:  o_ctrl.alu_op = ALU_XOR;
                  default: o_ctrl.alu_op = ALU_AND;
               endcase
            end
         end
         OP_LDR: begin
            o_ctrl.rf_we   = 1'b1;
            o_ctrl.nzp_we  = 1'b1;
            o_ctrl.imm_sel = 1'b1;
            o_ctrl.imm     = imm6;
            o_ctrl.wb_src  = WB_MEM;
            o_ctrl.is_load = 1'b1;
         end
         OP_STR: begin
            // Store data register sits in the rd field
            o_ctrl.rt       = i_insn[RD_HI:RD_LO];
            o_ctrl.imm_sel  = 1'b1;
            o_ctrl.imm      = imm6;
            o_ctrl.is_store = 1'b1;
         end
         OP_RTI: begin
            o_ctrl.rs     = LINK_REG;
            o_ctrl.pc_src = PC_RS;
         end
         OP_CONST: begin
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
            o_ctrl.alu_op = ALU_PASS_IMM;
            o_ctrl.imm    = imm9;
         end
         OP_JSR: begin
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
            o_ctrl.rd     = LINK_REG;
            o_ctrl.wb_src = WB_PC_PLUS_ONE;
            if (i_insn[JFORM_BIT]) begin
               o_ctrl.pc_src = PC_JSR_IMM;
               // Target offset is imm11 scaled by 16
               o_ctrl.imm    = {1'b0, i_insn[10:0], 4'b0000};
            end else begin
               o_ctrl.pc_src = PC_RS;
            end
         end
         OP_JMP: begin
            if (i_insn[JFORM_BIT]) begin
               o_ctrl.pc_src = PC_JMP_IMM;
               o_ctrl.imm    = imm11;
            end else begin
               o_ctrl.pc_src = PC_RS;
            end
         end
         OP_HICONST: begin
            // Low byte of rd is kept, so rd is also read as rs
            o_ctrl.rs      = i_insn[RD_HI:RD_LO];
            o_ctrl.rf_we   = 1'b1;
            o_ctrl.nzp_we  = 1'b1;
            o_ctrl.alu_op  = ALU_HI_MERGE;
            o_ctrl.imm_sel = 1'b1;
            o_ctrl.imm     = uimm8;
         end
         OP_TRAP: begin
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
            o_ctrl.rd     = LINK_REG;
            o_ctrl.wb_src = WB_PC_PLUS_ONE;
            o_ctrl.pc_src = PC_TRAP;
            o_ctrl.imm    = uimm8;
         end
         // Dropped opcodes decode as a NOP
         default: o_ctrl.pc_src = PC_SEQ;
      endcase
   end

   // Only kept opcodes should ever reach the core
   always_comb begin
      if (!$isunknown(i_insn)) begin
         assert (opc inside {OP_BR, OP_ARITH, OP_JSR, OP_LOGIC, OP_LDR, OP_STR,
                             OP_RTI, OP_CONST, OP_JMP, OP_HICONST, OP_TRAP})
            else $error("Unsupported opcode %h", i_insn[OPC_HI:OPC_LO]);
      end
   end

endmodule

`default_nettype wire

/* lc4_ctrl_pkg.sv */
`default_nettype none

package lc4_ctrl_pkg;

   import lc4_isa_pkg::*;

   // Functions performed by the ALU
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_MUL,
      ALU_SUB,
      ALU_AND,
      ALU_NOT,
      ALU_OR,
      ALU_XOR,
      // CONST passes the immediate through
      ALU_PASS_IMM,
      // HICONST merges the immediate byte over the top of rs
      ALU_HI_MERGE
   } alu_op_e;

   // Source of register writeback data
   typedef enum logic [1:0] {
      WB_ALU,
      WB_MEM,
      WB_PC_PLUS_ONE
   } wb_src_e;

   // Source of the next PC
   typedef enum logic [2:0] {
      PC_SEQ,
      PC_BRANCH,
      PC_JSR_IMM,
      PC_JMP_IMM,
      // JSRR, JMPR and RTI all jump to rs
      PC_RS,
      PC_TRAP
   } pc_src_e;

   // Decoded control for one instruction
   typedef struct packed {
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t rd;
      logic     rf_we;
      logic     nzp_we;
      alu_op_e  alu_op;
      logic     imm_sel;
      word_t    imm;
      wb_src_e  wb_src;
      pc_src_e  pc_src;
      logic     is_load;
      logic     is_store;
   } ctrl_t;

   // Data memory request
   typedef struct packed {
      logic  we;
      word_t addr;
      word_t data;
   } dmem_req_t;

endpackage

`default_nettype wire

/* lc4_isa_pkg.sv */
`default_nettype none

package lc4_isa_pkg;

   // Machine word for data, addresses and instructions
   typedef logic [15:0] word_t;

   // Index into the eight-entry register file
   typedef logic [2:0] reg_idx_t;

   // Major opcodes kept by this core, taken from insn[15:12]
   typedef enum logic [3:0] {
      OP_BR      = 4'h0,
      OP_ARITH   = 4'h1,
      OP_JSR     = 4'h4,
      OP_LOGIC   = 4'h5,
      OP_LDR     = 4'h6,
      OP_STR     = 4'h7,
      OP_RTI     = 4'h8,
      OP_CONST   = 4'h9,
      OP_JMP     = 4'hC,
      OP_HICONST = 4'hD,
      OP_TRAP    = 4'hF
   } opcode_e;

   // Instruction field positions
   localparam int OPC_HI = 15;
   localparam int OPC_LO = 12;
   localparam int RD_HI  = 11;
   localparam int RD_LO  = 9;
   localparam int RS_HI  = 8;
   localparam int RS_LO  = 6;
   localparam int RT_HI  = 2;
   localparam int RT_LO  = 0;
   // Sub-opcode of ARITH and LOGIC
   localparam int SUB_HI = 5;
   localparam int SUB_LO = 3;
   // Set for the immediate form of ADD and AND
   localparam int IMM_BIT   = 5;
   // Set for JSR and JMP, clear for JSRR and JMPR
   localparam int JFORM_BIT = 11;

   // Boot address of the PC
   localparam word_t RESET_PC  = 16'h8200;
   // OR'ed with the 8-bit trap vector
   localparam word_t TRAP_BASE = 16'h8000;
   // Top PC bit survives a JSR
   localparam word_t JSR_MASK  = 16'h8000;
   // R7 holds the return address
   localparam reg_idx_t LINK_REG = 3'd7;

   // Condition codes
   localparam logic [2:0] NZP_N = 3'b100;
   localparam logic [2:0] NZP_Z = 3'b010;
   localparam logic [2:0] NZP_P = 3'b001;

endpackage

`default_nettype wire
